// File: logic/matrix_to_vector.sv
`timescale 1ns/10ps
`default_nettype none
`include "tile_cfg.svh"

module matrix_to_vector (
    input  wire              clk,
    input  wire              rst,
    input  wire  tile_pkg::depth_t depth,
    input  wire  tile_pkg::tile_t  in_tile,
    input  wire              in_valid,
    output logic             in_ready,
    output tile_pkg::row_t   out_row,
    output logic             out_valid,
    input  wire              out_ready,
    output logic             busy,
    output logic             band_done
);
    import tile_pkg::*;

    localparam int RW = $clog2(`TILE_P1 + 1);

    typedef enum logic [1:0] {st_idle, st_load, st_process, st_finished} state_t;

    state_t state;
    state_t next;
    depth_t depth_q;     // Depth of the running band
    depth_t tile_q;      // Tiles accepted, then tile index while draining
    depth_t band_depth;
    cnt_t beat_q;
    cnt_t limit;
    logic [RW-1:0] wr_idx;   // Next upper row to store
    logic [RW-1:0] pass_q;   // Row pass_q+1 is due on this pass
    logic [RW-1:0] k_q;      // Position among the tile's remaining rows
    logic [RW-1:0] grp_last;
    logic pending;
    tile_t upper_q;
    logic out_free;
    logic out_fire;
    logic accept;
    logic pop;
    logic emit;
    row_t fifo_in;
    row_t fifo_out;
    logic fifo_in_valid;
    logic fifo_in_ready;
    logic fifo_out_valid;
    logic fifo_out_ready;

    row_fifo i_row_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_row    (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_row   (fifo_out),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    assign band_depth = (tile_q == '0) ? depth : depth_q; // Sampled on the first tile
    assign limit = cnt_t'(depth_q * `TILE_P1);
    assign out_free = !out_valid || out_ready;
    assign out_fire = out_valid && out_ready;
    assign in_ready = (state == st_load) && !pending && out_free;
    assign accept = in_valid && in_ready;

    // Head is either the row due now or a later row that goes round again
    assign grp_last = RW'(`TILE_P1 - 2) - pass_q;
    assign emit = (k_q == '0);
    assign fifo_out_ready = (state == st_process) && !pending && (!emit || out_free);
    assign pop = fifo_out_valid && fifo_out_ready;
    assign fifo_in = pending ? upper_q[wr_idx] : fifo_out;
    assign fifo_in_valid = pending || (pop && !emit);

    assign band_done = (state == st_process) && out_fire && (beat_q == limit - 1'b1);
    assign busy = (state == st_process) || (state == st_finished)
                  || ((state == st_load) && (tile_q != '0));

    always_comb begin
        next = state;
        case (state)
            st_idle: next = st_load;
            st_load: if (accept && (tile_q == band_depth - 1'b1)) next = st_process;
            st_process: if (band_done) next = st_finished;
            st_finished: next = st_load;
            default: next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            depth_q <= '0;
            tile_q <= '0;
            beat_q <= '0;
            wr_idx <= '0;
            pass_q <= '0;
            k_q <= '0;
            pending <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state <= next;
            if (accept) begin
                if (tile_q == '0)
                    depth_q <= depth;
                tile_q <= (tile_q == band_depth - 1'b1) ? '0 : tile_q + 1'b1;
                pending <= 1'b1;
                wr_idx <= RW'(1);
            end else if (pop) begin
                if (k_q == grp_last) begin
                    k_q <= '0;
                    if (tile_q == depth_q - 1'b1) begin
                        tile_q <= '0;
                        pass_q <= pass_q + 1'b1;
                    end else begin
                        tile_q <= tile_q + 1'b1;
                    end
                end else begin
                    k_q <= k_q + 1'b1;
                end
            end
            if (pending && fifo_in_ready) begin // One upper row per cycle
                pending <= (wr_idx != RW'(`TILE_P1 - 1));
                wr_idx <= wr_idx + 1'b1;
            end
            if (state == st_finished)
                pass_q <= '0;
            if (band_done)
                beat_q <= '0;
            else if (out_fire)
                beat_q <= beat_q + 1'b1;
            if (out_free)
                out_valid <= accept || (pop && emit);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_row <= in_tile[0];
            upper_q <= in_tile;
        end else if (pop && emit) begin
            out_row <= fifo_out;
        end
    end

endmodule

`default_nettype wire

// File: logic/row_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "tile_cfg.svh"

module row_fifo (
    input  wire             clk,
    input  wire             rst,
    input  wire  tile_pkg::row_t in_row,
    input  wire             in_valid,
    output logic            in_ready,
    output tile_pkg::row_t  out_row,
    output logic            out_valid,
    input  wire             out_ready
);
    import tile_pkg::*;

    // Room for the upper rows of a full band
    localparam int DEPTH = (`TILE_P1 > 1) ? `TILE_MAX_DEPTH * (`TILE_P1 - 1) : 1;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    row_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0] count;
    logic push;
    logic pop;

    assign out_valid = (count != '0);
    assign out_row = mem[rd_ptr];
    assign pop = out_valid && out_ready;
    assign in_ready = (count != (PW+1)'(DEPTH)) || out_ready; // Full but draining is fine
    assign push = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_row;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/tile_cfg.svh
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Tile shape, elements per row and rows per tile
`define TILE_P0 4
`define TILE_P1 2

`define TILE_PREC 8 // Element width in bits

// Tiles per band
`define TILE_MAX_DEPTH 8
`define TILE_DEPTH_RESET 4

`define TILE_AXIL_AW 4

`endif

// File: logic/tile_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "tile_cfg.svh"

module tile_cfg_regs (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  tile_pkg::axil_req_t axil_req,
    output tile_pkg::axil_rsp_t  axil_rsp,
    input  wire                  busy,
    input  wire                  band_done,
    output tile_pkg::depth_t     depth
);
    import tile_pkg::*;

    logic wr_fire;
    logic rd_fire;
    logic depth_ok;
    logic b_valid_q;
    resp_t b_resp_q;
    logic r_valid_q;
    resp_t r_resp_q;
    resp_t rd_resp;
    logic [31:0] r_data_q;
    logic [31:0] rd_data;
    logic [31:0] bands_q;

    // AW and W are taken together, one write in flight
    assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_valid_q;
    assign rd_fire = axil_req.ar_valid && !r_valid_q;
    assign depth_ok = (axil_req.w_data != 32'd0) && (axil_req.w_data <= `TILE_MAX_DEPTH);

    always_comb begin
        axil_rsp = '0;
        axil_rsp.aw_ready = wr_fire;
        axil_rsp.w_ready = wr_fire;
        axil_rsp.b_valid = b_valid_q;
        axil_rsp.b_resp = b_resp_q;
        axil_rsp.ar_ready = rd_fire;
        axil_rsp.r_valid = r_valid_q;
        axil_rsp.r_data = r_data_q;
        axil_rsp.r_resp = r_resp_q;
    end

    always_comb begin
        rd_data = 32'd0;
        rd_resp = resp_okay;
        case (axil_req.ar_addr)
            reg_depth: rd_data = 32'(depth);
            reg_status: rd_data = {31'd0, busy};
            reg_bands: rd_data = bands_q;
            default: rd_resp = resp_slverr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid_q <= 1'b0;
            b_resp_q <= resp_okay;
            depth <= depth_t'(`TILE_DEPTH_RESET);
        end else if (wr_fire) begin
            b_valid_q <= 1'b1;
            b_resp_q <= resp_okay;
            if (axil_req.aw_addr != reg_depth)
                b_resp_q <= resp_slverr; // Read-only or unmapped
            else if (!depth_ok)
                b_resp_q <= resp_slverr;
            else if (axil_req.w_strb[0])
                depth <= depth_t'(axil_req.w_data);
        end else if (axil_req.b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
            r_resp_q <= resp_okay;
        end else if (rd_fire) begin
            r_valid_q <= 1'b1;
            r_resp_q <= rd_resp;
        end else if (axil_req.r_ready) begin
            r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            r_data_q <= rd_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            bands_q <= 32'd0;
        else if (band_done)
            bands_q <= bands_q + 32'd1; // Wraps
    end

endmodule

`default_nettype wire

// File: logic/tile_pkg.sv
`default_nettype none
`include "tile_cfg.svh"

package tile_pkg;

    typedef logic [`TILE_PREC-1:0] elem_t;
    typedef elem_t [`TILE_P0-1:0] row_t; // One output vector
    typedef row_t [`TILE_P1-1:0] tile_t; // Row 0 leaves first

    typedef logic [$clog2(`TILE_MAX_DEPTH + 1)-1:0] depth_t;
    typedef logic [$clog2(`TILE_MAX_DEPTH * `TILE_P1 + 1)-1:0] cnt_t;

    typedef logic [1:0] resp_t;
    typedef logic [`TILE_AXIL_AW-1:0] axil_addr_t;

    localparam resp_t resp_okay = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    localparam axil_addr_t reg_depth = 'h0;
    localparam axil_addr_t reg_status = 'h4;
    localparam axil_addr_t reg_bands = 'h8;

    typedef struct packed {
        logic aw_valid;
        axil_addr_t aw_addr;
        logic w_valid;
        logic [31:0] w_data;
        logic [3:0] w_strb;
        logic b_ready;
        logic ar_valid;
        axil_addr_t ar_addr;
        logic r_ready;
    } axil_req_t;

    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
        resp_t b_resp;
        logic ar_ready;
        logic r_valid;
        logic [31:0] r_data;
        resp_t r_resp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: logic/tile_raster_top.sv
`timescale 1ns/10ps
`default_nettype none

module tile_raster_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  tile_pkg::axil_req_t axil_req,
    output tile_pkg::axil_rsp_t  axil_rsp,
    input  wire  tile_pkg::tile_t  in_tile,
    input  wire                  in_valid,
    output logic                 in_ready,
    output tile_pkg::row_t       out_row,
    output logic                 out_valid,
    input  wire                  out_ready
);
    import tile_pkg::*;

    depth_t depth;
    logic busy;
    logic band_done;

    tile_cfg_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .busy      (busy),
        .band_done (band_done),
        .depth     (depth)
    );

    matrix_to_vector i_m2v (
        .clk       (clk),
        .rst       (rst),
        .depth     (depth),
        .in_tile   (in_tile),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_row   (out_row),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy),
        .band_done (band_done)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/tile_pkg.sv
logic/row_fifo.sv
logic/matrix_to_vector.sv
logic/tile_cfg_regs.sv
logic/tile_raster_top.sv
test/tb_tile_raster.sv

// File: test/tb_tile_raster.sv
`timescale 1ns/10ps
`default_nettype none
`include "tile_cfg.svh"

module tb_tile_raster;
    import tile_pkg::*;

    localparam int wait_limit = 600; // Cycles per wait loop

    logic clk;
    logic rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    tile_t in_tile;
    logic in_valid;
    logic in_ready;
    row_t out_row;
    logic out_valid;
    logic out_ready;
    logic stall_on;
    int errors;
    int bands_exp;
    row_t exp_q[$];
    tile_t band_tiles [`TILE_MAX_DEPTH];

    tile_raster_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .in_tile   (in_tile),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_row   (out_row),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s = %b, expected %b",
                                $time, name, got, exp));
    endtask

    // Every accepted output row must be the oldest expected one
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0)
                abort_run("An output row appeared while none was expected");
            else
                check_row("out_row", out_row, exp_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (stall_on)
            out_ready = ($urandom_range(3, 0) != 0);
        else
            out_ready = 1'b1;
    end

    task automatic axil_write(input axil_addr_t addr, input logic [31:0] data,
                              output resp_t resp);
        int n;
        @(negedge clk);
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr = addr;
        axil_req.w_valid = 1'b1;
        axil_req.w_data = data;
        axil_req.w_strb = 4'hf;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(axil_rsp.aw_ready && axil_rsp.w_ready) && n < wait_limit);
        if (!(axil_rsp.aw_ready && axil_rsp.w_ready))
            abort_run("Timed out waiting for the register block to take a write");
        @(negedge clk);
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid = 1'b0;
        axil_req.b_ready = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.b_valid && n < wait_limit);
        if (!axil_rsp.b_valid)
            abort_run("Timed out waiting for a write response");
        resp = axil_rsp.b_resp;
        @(negedge clk);
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output logic [31:0] data,
                             output resp_t resp);
        int n;
        @(negedge clk);
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr = addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.ar_ready && n < wait_limit);
        if (!axil_rsp.ar_ready)
            abort_run("Timed out waiting for the register block to take a read");
        @(negedge clk);
        axil_req.ar_valid = 1'b0;
        axil_req.r_ready = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.r_valid && n < wait_limit);
        if (!axil_rsp.r_valid)
            abort_run("Timed out waiting for read data");
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(negedge clk);
        axil_req.r_ready = 1'b0;
    endtask

    task automatic read_and_check(input axil_addr_t addr, input string name,
                                  input logic [31:0] exp);
        logic [31:0] data;
        resp_t resp;
        axil_read(addr, data, resp);
        check_resp({name, " read resp"}, resp, resp_okay);
        check_word(name, data, exp);
    endtask

    task automatic write_and_check(input logic [31:0] data, input resp_t exp_resp);
        resp_t resp;
        axil_write(reg_depth, data, resp);
        check_resp("DEPTH write resp", resp, exp_resp);
    endtask

    // Random tiles, expected rows queued as row r of every tile before row r+1
    task automatic make_band(input int n);
        for (int t = 0; t < n; t++)
            for (int r = 0; r < `TILE_P1; r++)
                for (int e = 0; e < `TILE_P0; e++)
                    band_tiles[t][r][e] = elem_t'($urandom);
        for (int r = 0; r < `TILE_P1; r++)
            for (int t = 0; t < n; t++)
                exp_q.push_back(band_tiles[t][r]);
    endtask

    task automatic send_tile(input tile_t tile, input int gap);
        int n;
        repeat (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        in_tile = tile;
        in_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_ready && n < wait_limit);
        if (!in_ready)
            abort_run("Timed out waiting for the serializer to take a tile");
    endtask

    task automatic run_band(input int n, input int gap_max);
        make_band(n);
        for (int t = 0; t < n; t++)
            send_tile(band_tiles[t], (gap_max > 0) ? $urandom_range(gap_max, 0) : 0);
        @(negedge clk);
        in_valid = 1'b0;
        bands_exp++;
    endtask

    task automatic expect_rows();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 4 * wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            abort_run($sformatf("Timed out with %0d output rows still missing", exp_q.size()));
    endtask

    task automatic test_reset_values();
        read_and_check(reg_depth, "DEPTH", `TILE_DEPTH_RESET);
        read_and_check(reg_status, "STATUS", 32'd0);
        read_and_check(reg_bands, "BANDS", 32'd0);
    endtask

    task automatic test_single_band();
        make_band(`TILE_DEPTH_RESET);
        send_tile(band_tiles[0], 0);
        @(negedge clk);
        in_valid = 1'b0;
        read_and_check(reg_status, "STATUS", 32'd1); // Band under way
        for (int t = 1; t < `TILE_DEPTH_RESET; t++)
            send_tile(band_tiles[t], 0);
        @(negedge clk);
        in_valid = 1'b0;
        bands_exp++;
        expect_rows();
        read_and_check(reg_status, "STATUS", 32'd0);
        read_and_check(reg_bands, "BANDS", bands_exp);
    endtask

    task automatic test_depth_changes();
        write_and_check(32'd1, resp_okay);
        run_band(1, 0);
        run_band(1, 0);
        expect_rows();
        read_and_check(reg_bands, "BANDS", bands_exp);
        write_and_check(32'd3, resp_okay);
        read_and_check(reg_depth, "DEPTH", 32'd3);
        run_band(3, 0);
        run_band(3, 0);
        expect_rows();
        read_and_check(reg_bands, "BANDS", bands_exp);
    endtask

    task automatic test_random_stalls();
        write_and_check(`TILE_MAX_DEPTH, resp_okay);
        stall_on = 1'b1;
        repeat (4)
            run_band(`TILE_MAX_DEPTH, 3);
        expect_rows();
        stall_on = 1'b0;
        read_and_check(reg_bands, "BANDS", bands_exp);
    endtask

    task automatic test_bad_depth();
        write_and_check(32'd0, resp_slverr);
        write_and_check(`TILE_MAX_DEPTH + 1, resp_slverr);
        read_and_check(reg_depth, "DEPTH", `TILE_MAX_DEPTH);
    endtask

    initial begin
        void'($urandom(32'h12f4_b7bd));
        clk = 1'b0;
        rst = 1'b1;
        axil_req = '0;
        in_tile = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        stall_on = 1'b0;
        errors = 0;
        bands_exp = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_values();
        test_single_band();
        test_depth_changes();
        test_random_stalls();
        test_bad_depth();

        repeat (10) @(posedge clk); // Stray rows would show up here
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
